/* logic/xsec_config.svh */
`ifndef XSEC_CONFIG_SVH
`define XSEC_CONFIG_SVH

// Data and instruction width
`define XSEC_XLEN 32

// Default LFSR seeds, loaded at reset and on lockup
`define XSEC_LFSR0_SEED 32'h2B1C_0A57
`define XSEC_LFSR1_SEED 32'h91E4_6D3B
`define XSEC_LFSR2_SEED 32'h5F07_C2A9

// Galois feedback mask shared by all three LFSRs
`define XSEC_LFSR_TAPS 32'h8000_0057

// Seed CSR addresses
`define XSEC_CSR_SEED0 12'hBF9
`define XSEC_CSR_SEED1 12'hBFA
`define XSEC_CSR_SEED2 12'hBFC

// Control CSR, bit 0 is the dummy enable and bits 4..1 the frequency
`define XSEC_CSR_CPUCTRL 12'hBF0

// Width of the frequency field
`define XSEC_FREQ_W 4

`endif

/* logic/xsec_pkg.sv */
`default_nettype none

package xsec_pkg;

  // R-type view of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  // B-type view, immediate split over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef union packed {
    insn_r_t r;
    insn_b_t b;
  } insn_u;

  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_kind_e;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

/* logic/seed_if.sv */
`default_nettype none
`include "xsec_config.svh"

interface seed_if;

  // One write strobe per LFSR, shared write data
  logic [2:0]            seed_we;
  logic [`XSEC_XLEN-1:0] seed_wdata;

  // Current LFSR state for CSR readback
  logic [`XSEC_XLEN-1:0] lfsr0;
  logic [`XSEC_XLEN-1:0] lfsr1;
  logic [`XSEC_XLEN-1:0] lfsr2;

  modport cfg (
    output seed_we, seed_wdata,
    input  lfsr0, lfsr1, lfsr2
  );

  modport lfsr (
    input  seed_we, seed_wdata,
    output lfsr0, lfsr1, lfsr2
  );

endinterface

`default_nettype wire

/* logic/dummy_cfg_regs.sv */
`default_nettype none
`include "xsec_config.svh"

module dummy_cfg_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    csr_we,
  input  logic [11:0]             csr_waddr,
  input  logic [`XSEC_XLEN-1:0]   csr_wdata,
  input  logic [11:0]             csr_raddr,
  output logic [`XSEC_XLEN-1:0]   csr_rdata,
  seed_if.cfg                     seed,
  output logic                    dummy_en,
  output logic [`XSEC_FREQ_W-1:0] dummy_freq
);

  logic ctrl_we;

  assign ctrl_we = csr_we && (csr_waddr == `XSEC_CSR_CPUCTRL);

  // Control register with enable and frequency
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dummy_en   <= 1'b0;
      dummy_freq <= '0;
    end else if (ctrl_we) begin
      dummy_en   <= csr_wdata[0];
      dummy_freq <= csr_wdata[`XSEC_FREQ_W:1];
    end
  end

  // Seed writes go straight to the LFSR bank and land on the next edge
  always_comb begin
    seed.seed_we = 3'b000;
    if (csr_we) begin
      case (csr_waddr)
        `XSEC_CSR_SEED0: seed.seed_we = 3'b001;
        `XSEC_CSR_SEED1: seed.seed_we = 3'b010;
        `XSEC_CSR_SEED2: seed.seed_we = 3'b100;
        default:         seed.seed_we = 3'b000;
      endcase
    end
  end

  assign seed.seed_wdata = csr_wdata;

  // Readback mux
  always_comb begin
    csr_rdata = '0;
    case (csr_raddr)
      `XSEC_CSR_CPUCTRL: begin
        csr_rdata[0]                = dummy_en;
        csr_rdata[`XSEC_FREQ_W:1]   = dummy_freq;
      end
      `XSEC_CSR_SEED0: csr_rdata = seed.lfsr0;
      `XSEC_CSR_SEED1: csr_rdata = seed.lfsr1;
      `XSEC_CSR_SEED2: csr_rdata = seed.lfsr2;
      default:         csr_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/lfsr_bank.sv */
`default_nettype none
`include "xsec_config.svh"

module lfsr_bank (
  input  logic clk_i,
  input  logic rst_ni,
  seed_if.lfsr seed,
  input  logic lfsr_step0,
  input  logic lfsr_step1
);

  localparam int unsigned NUM_LFSR = 3;

  localparam logic [NUM_LFSR-1:0][`XSEC_XLEN-1:0] DEFAULT_SEED = {
    `XSEC_LFSR2_SEED,
    `XSEC_LFSR1_SEED,
    `XSEC_LFSR0_SEED
  };

  logic [NUM_LFSR-1:0][`XSEC_XLEN-1:0] lfsr_q;
  logic [NUM_LFSR-1:0][`XSEC_XLEN-1:0] lfsr_cand;
  logic [NUM_LFSR-1:0][`XSEC_XLEN-1:0] lfsr_d;
  logic [NUM_LFSR-1:0]                 step;

  // One Galois shift, feedback from the bit that falls out
  function automatic logic [`XSEC_XLEN-1:0] galois_step(input logic [`XSEC_XLEN-1:0] cur);
    logic [`XSEC_XLEN-1:0] shifted;
    shifted = {1'b0, cur[`XSEC_XLEN-1:1]};
    if (cur[0]) begin
      shifted = shifted ^ `XSEC_LFSR_TAPS;
    end
    return shifted;
  endfunction

  // Operand LFSRs advance together
  assign step = {lfsr_step1, lfsr_step1, lfsr_step0};

  for (genvar i = 0; i < NUM_LFSR; i++) begin : g_lfsr

    // Seed write has priority over a step
    always_comb begin
      if (seed.seed_we[i]) begin
        lfsr_cand[i] = seed.seed_wdata;
      end else if (step[i]) begin
        lfsr_cand[i] = galois_step(lfsr_q[i]);
      end else begin
        lfsr_cand[i] = lfsr_q[i];
      end
    end

    // Lockup guard, an all-zero state would never leave zero
    assign lfsr_d[i] = (lfsr_cand[i] == '0) ? DEFAULT_SEED[i] : lfsr_cand[i];

    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        lfsr_q[i] <= DEFAULT_SEED[i];
      end else begin
        lfsr_q[i] <= lfsr_d[i];
      end
    end

  end

  assign seed.lfsr0 = lfsr_q[0];
  assign seed.lfsr1 = lfsr_q[1];
  assign seed.lfsr2 = lfsr_q[2];

endmodule

`default_nettype wire

/* logic/dummy_inserter.sv */
`default_nettype none
`include "xsec_config.svh"

module dummy_inserter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    dummy_en,
  input  logic [`XSEC_FREQ_W-1:0] dummy_freq,
  input  logic [`XSEC_XLEN-1:0]   lfsr0,
  input  logic [`XSEC_XLEN-1:0]   lfsr1,
  input  logic [`XSEC_XLEN-1:0]   lfsr2,
  input  logic                    in_valid,
  input  logic [`XSEC_XLEN-1:0]   in_instr,
  input  logic                    out_ready,
  output logic                    lfsr_step0,
  output logic                    lfsr_step1,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic [`XSEC_XLEN-1:0]   out_instr,
  output logic                    out_dummy,
  output logic [`XSEC_XLEN-1:0]   out_operand_a,
  output logic [`XSEC_XLEN-1:0]   out_operand_b
);

  // Counts up to a gap of 64
  localparam int unsigned GAP_W = 7;

  logic [GAP_W-1:0]      gap_q;
  logic [GAP_W-1:0]      gap_d;
  logic [GAP_W-1:0]      gap_new;
  logic                  en_q;
  logic                  en_rise;
  logic                  dummy_due;
  logic                  dummy_xfer;
  logic                  real_xfer;
  logic                  gap_load;
  xsec_pkg::dummy_kind_e kind;
  xsec_pkg::insn_u       dummy_insn;

  // Gap mask G-1 from the frequency field
  function automatic logic [GAP_W-2:0] gap_mask(input logic [`XSEC_FREQ_W-1:0] freq);
    logic [GAP_W-2:0] mask;
    casez (freq)
      4'b1???: mask = 6'd63;
      4'b01??: mask = 6'd31;
      4'b001?: mask = 6'd15;
      4'b0001: mask = 6'd7;
      default: mask = 6'd3;
    endcase
    return mask;
  endfunction

  // New gap in 1..G drawn from the low timing bits
  function automatic logic [GAP_W-1:0] gap_draw(input logic [`XSEC_XLEN-1:0] rnd,
                                                input logic [`XSEC_FREQ_W-1:0] freq);
    logic [GAP_W-2:0] low;
    low = rnd[GAP_W-2:0] & gap_mask(freq);
    return {1'b0, low} + GAP_W'(1);
  endfunction

  assign en_rise   = dummy_en && !en_q;
  assign dummy_due = dummy_en && en_q && (gap_q == '0);

  assign in_ready   = out_ready && !dummy_due;
  assign real_xfer  = in_valid && in_ready;
  assign dummy_xfer = dummy_due && out_ready;
  assign gap_load   = en_rise || dummy_xfer;

  assign lfsr_step0 = gap_load;
  assign lfsr_step1 = dummy_xfer;

  // A real transfer in the enable cycle already counts against the new gap
  assign gap_new = gap_draw(lfsr0, dummy_freq) - GAP_W'(real_xfer);

  always_comb begin
    gap_d = gap_q;
    if (gap_load) begin
      gap_d = gap_new;
    end else if (real_xfer && (gap_q != '0)) begin
      gap_d = gap_q - GAP_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      en_q  <= 1'b0;
      gap_q <= gap_draw(`XSEC_LFSR0_SEED, '0);
    end else begin
      en_q  <= dummy_en;
      gap_q <= gap_d;
    end
  end

  // Dummy encoding, kind picked by LFSR0
  assign kind = xsec_pkg::dummy_kind_e'(lfsr0[6:5]);

  always_comb begin
    dummy_insn = '0;
    case (kind)
      xsec_pkg::DUMMY_ADD: begin
        dummy_insn.r.funct7 = xsec_pkg::FUNCT7_BASE;
        dummy_insn.r.funct3 = xsec_pkg::FUNCT3_ADD;
        dummy_insn.r.opcode = xsec_pkg::OPCODE_OP;
      end
      xsec_pkg::DUMMY_AND: begin
        dummy_insn.r.funct7 = xsec_pkg::FUNCT7_BASE;
        dummy_insn.r.funct3 = xsec_pkg::FUNCT3_AND;
        dummy_insn.r.opcode = xsec_pkg::OPCODE_OP;
      end
      xsec_pkg::DUMMY_MUL: begin
        dummy_insn.r.funct7 = xsec_pkg::FUNCT7_MULDIV;
        dummy_insn.r.funct3 = xsec_pkg::FUNCT3_MUL;
        dummy_insn.r.opcode = xsec_pkg::OPCODE_OP;
      end
      default: begin
        // Branch to itself plus zero, falls through to the next real one
        dummy_insn.b.rs2    = 5'd2;
        dummy_insn.b.rs1    = 5'd1;
        dummy_insn.b.funct3 = xsec_pkg::FUNCT3_BLTU;
        dummy_insn.b.opcode = xsec_pkg::OPCODE_BRANCH;
      end
    endcase
  end

  // Stream mux
  assign out_valid     = dummy_due || in_valid;
  assign out_dummy     = dummy_due;
  assign out_instr     = dummy_due ? dummy_insn : in_instr;
  assign out_operand_a = dummy_due ? lfsr1 : '0;
  assign out_operand_b = dummy_due ? lfsr2 : '0;

endmodule

`default_nettype wire

/* logic/dummy_insn_top.sv */
`default_nettype none
`include "xsec_config.svh"

module dummy_insn_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  csr_we,
  input  logic [11:0]           csr_waddr,
  input  logic [`XSEC_XLEN-1:0] csr_wdata,
  input  logic [11:0]           csr_raddr,
  input  logic                  in_valid,
  input  logic [`XSEC_XLEN-1:0] in_instr,
  input  logic                  out_ready,
  output logic [`XSEC_XLEN-1:0] csr_rdata,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [`XSEC_XLEN-1:0] out_instr,
  output logic                  out_dummy,
  output logic [`XSEC_XLEN-1:0] out_operand_a,
  output logic [`XSEC_XLEN-1:0] out_operand_b
);

  logic                    dummy_en;
  logic [`XSEC_FREQ_W-1:0] dummy_freq;
  logic                    lfsr_step0;
  logic                    lfsr_step1;

  seed_if u_seed_if ();

  dummy_cfg_regs u_cfg_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .csr_we     (csr_we),
    .csr_waddr  (csr_waddr),
    .csr_wdata  (csr_wdata),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .seed       (u_seed_if.cfg),
    .dummy_en   (dummy_en),
    .dummy_freq (dummy_freq)
  );

  lfsr_bank u_lfsr_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .seed       (u_seed_if.lfsr),
    .lfsr_step0 (lfsr_step0),
    .lfsr_step1 (lfsr_step1)
  );

  // LFSR state is taken from the seed interface
  dummy_inserter u_inserter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dummy_en      (dummy_en),
    .dummy_freq    (dummy_freq),
    .lfsr0         (u_seed_if.lfsr0),
    .lfsr1         (u_seed_if.lfsr1),
    .lfsr2         (u_seed_if.lfsr2),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .out_ready     (out_ready),
    .lfsr_step0    (lfsr_step0),
    .lfsr_step1    (lfsr_step1),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_instr     (out_instr),
    .out_dummy     (out_dummy),
    .out_operand_a (out_operand_a),
    .out_operand_b (out_operand_b)
  );

endmodule

`default_nettype wire

/* tests/tb_dummy_insn.sv */
`default_nettype none
`include "xsec_config.svh"

module tb_dummy_insn;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned FREQ_CNT   = 5;
  localparam int unsigned PASS_CNT   = 24;
  localparam int unsigned FREQS [FREQ_CNT] = '{0, 1, 3, 7, 15};
  // Disabled run plus 2G+10 instructions per enabled run
  localparam int unsigned INSN_CNT = PASS_CNT + 18 + 26 + 42 + 74 + 138;
  localparam int unsigned WATCHDOG_CYCLES = 2 * (INSN_CNT * 64 + 200);

  logic        clk_i;
  logic        rst_ni;
  logic        csr_we;
  logic [11:0] csr_waddr;
  logic [31:0] csr_wdata;
  logic [11:0] csr_raddr;
  logic [31:0] csr_rdata;
  logic        in_valid;
  logic [31:0] in_instr;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] out_instr;
  logic        out_dummy;
  logic [31:0] out_operand_a;
  logic [31:0] out_operand_b;

  // Expected state kept alongside the DUT
  logic        en_model;
  logic [31:0] lfsr1_model;
  logic [31:0] lfsr2_model;
  logic [31:0] sent_q [$];
  int unsigned sent_total;
  int unsigned gap_max;
  int unsigned gap_count;
  int unsigned dummies_seen;
  int unsigned mismatches;
  int unsigned failures;

  dummy_insn_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_we        (csr_we),
    .csr_waddr     (csr_waddr),
    .csr_wdata     (csr_wdata),
    .csr_raddr     (csr_raddr),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .out_ready     (out_ready),
    .csr_rdata     (csr_rdata),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_instr     (out_instr),
    .out_dummy     (out_dummy),
    .out_operand_a (out_operand_a),
    .out_operand_b (out_operand_b)
  );

  // Right-shifting Galois step with lockup reload
  function automatic logic [31:0] lfsr_next(input logic [31:0] cur, input logic [31:0] dflt);
    logic [31:0] nxt;
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ `XSEC_LFSR_TAPS;
    end
    if (nxt == '0) begin
      nxt = dflt;
    end
    return nxt;
  endfunction

  function automatic int unsigned max_gap(input int unsigned freq);
    if (freq >= 8) return 64;
    if (freq >= 4) return 32;
    if (freq >= 2) return 16;
    if (freq == 1) return 8;
    return 4;
  endfunction

  // Register form with rd = x0, or BLTU with a zero offset
  function automatic bit legal_dummy(input logic [31:0] word);
    xsec_pkg::insn_u dec;
    bit              reg_form;
    bit              branch_form;
    dec = word;
    reg_form = (dec.r.opcode == xsec_pkg::OPCODE_OP) && (dec.r.rd == 5'd0) &&
               (((dec.r.funct7 == xsec_pkg::FUNCT7_BASE) &&
                 ((dec.r.funct3 == xsec_pkg::FUNCT3_ADD) ||
                  (dec.r.funct3 == xsec_pkg::FUNCT3_AND))) ||
                ((dec.r.funct7 == xsec_pkg::FUNCT7_MULDIV) &&
                 (dec.r.funct3 == xsec_pkg::FUNCT3_MUL)));
    branch_form = (dec.b.opcode == xsec_pkg::OPCODE_BRANCH) &&
                  (dec.b.funct3 == xsec_pkg::FUNCT3_BLTU) &&
                  ({dec.b.imm12, dec.b.imm11, dec.b.imm10_5, dec.b.imm4_1} == 12'd0);
    return reg_form || branch_form;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // Downstream back-pressure in a fixed pattern
  initial begin : ready_pattern
    int unsigned cyc;
    cyc = 0;
    out_ready = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      out_ready = ((cyc % 5) != 3) && ((cyc % 11) != 7) && ((cyc % 11) != 8);
      cyc++;
    end
  end

  quiet_when_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_model |-> !out_dummy)
    else begin
      mismatches++;
      $display("mismatch at %0t: dummy issued while insertion is disabled", $time);
    end

  pass_through: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !out_dummy |-> (out_valid == in_valid) && (out_instr == in_instr) &&
                   (in_ready == out_ready))
    else begin
      mismatches++;
      $display("mismatch at %0t: real stream not passed through unchanged", $time);
    end

  dummy_stalls_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_dummy |-> out_valid && !in_ready)
    else begin
      mismatches++;
      $display("mismatch at %0t: fetch not stalled while a dummy is offered", $time);
    end

  task automatic check_dummy();
    assert (legal_dummy(out_instr)) else begin
      mismatches++;
      $display("mismatch at %0t: illegal dummy encoding %h", $time, out_instr);
    end
    assert (out_operand_a == lfsr1_model &&
            (csr_raddr != `XSEC_CSR_SEED1 || out_operand_a == csr_rdata)) else begin
      mismatches++;
      $display("mismatch at %0t: operand a %h, expected %h", $time, out_operand_a, lfsr1_model);
    end
    assert (out_operand_b != '0 && out_operand_b == lfsr2_model) else begin
      mismatches++;
      $display("mismatch at %0t: operand b %h, expected %h", $time, out_operand_b, lfsr2_model);
    end
    lfsr1_model = lfsr_next(lfsr1_model, `XSEC_LFSR1_SEED);
    lfsr2_model = lfsr_next(lfsr2_model, `XSEC_LFSR2_SEED);
    dummies_seen++;
    gap_count = 0;
  endtask

  task automatic check_real();
    logic [31:0] expected;
    if (sent_q.size() == 0) begin
      failures++;
      $display("real instruction %h came out but was never sent", out_instr);
    end else begin
      expected = sent_q.pop_front();
      assert (out_instr == expected) else begin
        mismatches++;
        $display("mismatch at %0t: instruction %h, expected %h", $time, out_instr, expected);
      end
      if (en_model) begin
        gap_count++;
        assert (gap_count <= gap_max) else begin
          mismatches++;
          $display("mismatch at %0t: %0d real transfers without a dummy, limit %0d",
                   $time, gap_count, gap_max);
        end
      end
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && out_valid && out_ready) begin
      if (out_dummy) begin
        check_dummy();
      end else begin
        check_real();
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    csr_we    = 1'b1;
    csr_waddr = addr;
    csr_wdata = data;
    next_cycle();
    csr_we = 1'b0;
    case (addr)
      `XSEC_CSR_SEED1: lfsr1_model = (data == '0) ? `XSEC_LFSR1_SEED : data;
      `XSEC_CSR_SEED2: lfsr2_model = (data == '0) ? `XSEC_LFSR2_SEED : data;
      `XSEC_CSR_CPUCTRL: begin
        en_model  = data[0];
        gap_max   = max_gap(data[4:1]);
        gap_count = 0;
      end
      default: ;
    endcase
  endtask

  task automatic check_readback(input logic [11:0] addr, input logic [31:0] expected);
    csr_raddr = addr;
    @(negedge clk_i);
    assert (csr_rdata == expected) else begin
      mismatches++;
      $display("mismatch at %0t: CSR %h read %h, expected %h", $time, addr, csr_rdata, expected);
    end
    next_cycle();
    csr_raddr = `XSEC_CSR_SEED1;
  endtask

  task automatic seed_roundtrip(input logic [11:0] addr, input logic [31:0] value,
                                input logic [31:0] dflt);
    csr_write(addr, value);
    check_readback(addr, value);
    // Zero would lock the LFSR up
    csr_write(addr, 32'd0);
    check_readback(addr, dflt);
  endtask

  // Holds each instruction until the DUT takes it
  task automatic send_insns(input int unsigned count);
    bit taken;
    for (int unsigned i = 0; i < count; i++) begin
      in_valid = 1'b1;
      in_instr = (sent_total << 12) | 32'h13;
      sent_q.push_back(in_instr);
      sent_total++;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = in_ready;
        next_cycle();
      end
      in_valid = 1'b0;
      if ((i % 3) == 2) begin
        next_cycle();
      end
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main_seq
    rst_ni       = 1'b0;
    csr_we       = 1'b0;
    csr_waddr    = '0;
    csr_wdata    = '0;
    csr_raddr    = `XSEC_CSR_SEED1;
    in_valid     = 1'b0;
    in_instr     = '0;
    en_model     = 1'b0;
    lfsr1_model  = `XSEC_LFSR1_SEED;
    lfsr2_model  = `XSEC_LFSR2_SEED;
    sent_total   = 0;
    gap_max      = 4;
    gap_count    = 0;
    dummies_seen = 0;
    mismatches   = 0;
    failures     = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_readback(`XSEC_CSR_SEED0, `XSEC_LFSR0_SEED);
    check_readback(`XSEC_CSR_SEED1, `XSEC_LFSR1_SEED);
    check_readback(`XSEC_CSR_SEED2, `XSEC_LFSR2_SEED);
    check_readback(`XSEC_CSR_CPUCTRL, 32'd0);
    send_insns(PASS_CNT);

    seed_roundtrip(`XSEC_CSR_SEED0, 32'hA5C3_0F1E, `XSEC_LFSR0_SEED);
    seed_roundtrip(`XSEC_CSR_SEED1, 32'h1357_9BDF, `XSEC_LFSR1_SEED);
    seed_roundtrip(`XSEC_CSR_SEED2, 32'hFEDC_0042, `XSEC_LFSR2_SEED);

    for (int unsigned f = 0; f < FREQ_CNT; f++) begin
      csr_write(`XSEC_CSR_CPUCTRL, (FREQS[f] << 1) | 32'd1);
      dummies_seen = 0;
      send_insns(2 * max_gap(FREQS[f]) + 10);
      csr_write(`XSEC_CSR_CPUCTRL, 32'd0);
      assert (dummies_seen > 0) else begin
        failures++;
        $display("no dummy instruction appeared at frequency %0d", FREQS[f]);
      end
    end

    if (sent_q.size() != 0) begin
      failures++;
      $display("%0d sent instructions never reached the output", sent_q.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/xsec_pkg.sv
logic/seed_if.sv
logic/dummy_cfg_regs.sv
logic/lfsr_bank.sv
logic/dummy_inserter.sv
logic/dummy_insn_top.sv
tests/tb_dummy_insn.sv

/* Bender.yml */
package:
  name: dummy_insn

sources:
  - include_dirs:
      - logic
    files:
      - logic/xsec_pkg.sv
      - logic/seed_if.sv
      - logic/dummy_cfg_regs.sv
      - logic/lfsr_bank.sv
      - logic/dummy_inserter.sv
      - logic/dummy_insn_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_dummy_insn.sv
